/* Makefile */
# Verilator build and run of the nora_core testbench

LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, check $(LOG) for a failure"
	@echo "  clean  remove obj_dir and $(LOG)"

test:
	verilator --binary --timing --assert -Wno-fatal -f all.f \
		--top-module tb_nora_core -o tb_sim
	-./obj_dir/tb_sim > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q '\*\* FAIL \*\*' $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q '\*\* PASS \*\*' $(LOG) || (echo "no pass message"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

/* all.f */
src/nora_pkg.sv
src/cpu_phaser.sv
src/bus_sampler.sv
src/trace_buffer.sv
src/icd_regs.sv
src/nora_core.sv
sim/tb_nora_core.sv

/* sim/tb_nora_core.sv */
// tb_nora_core: clock, reset, random cpu pins, reference model, compare tasks, watchdog
`timescale 1ns/1ps
`default_nettype none

module tb_nora_core;

    import nora_pkg::*;

    localparam int L      = 6;              // default CYCLE_LEN of the dut
    localparam int HALF   = L / 2;
    localparam int DEPTH  = 8;
    localparam int N_CPU  = 64;             // warm-up, five trace runs, wrap run, stop slack
    localparam int N_DBG  = 520;            // rough count of debug accesses
    localparam int LIMIT  = N_CPU * L + N_DBG * 4 + 1000;

    logic      clk6x;
    logic      rst_n_i;
    cpu_addr_t cpu_addr_i;
    cpu_byte_t cpu_data_i;
    logic      cpu_mx_i, cpu_sync_vpa_i, cpu_mln_i, cpu_vpn_i, cpu_vda_i;
    logic      cpu_ef_i, cpu_rwn_i, cpu_rdy_i;
    logic      cputype02_i, virqn_i, nmi_req_n_i;
    logic      dbg_wr_i, dbg_rd_i;
    dbg_addr_t dbg_addr_i;
    cpu_byte_t dbg_wdata_i;
    wire       cpu_phi2_o, cpu_resn_o, cpu_irqn_o, cpu_nmin_o, cpu_abortn_o;
    wire       cpu_stopped_o, dbg_rvalid_o;
    cpu_byte_t dbg_rdata_o;

    integer    seed = 32'h2634_f71c;

    // model state
    cpu_byte_t   m_ctrl;
    int          m_cnt;
    logic        m_run_q, m_stop, m_latch, m_rel, m_t02;
    cpu_byte_t   m_bank;
    cpu_addr_t   m_addr;
    logic        m_xf, m_mflag, m_sync, m_mln, m_vpn, m_vda, m_ef, m_rwn;
    int          m_rel_cnt;
    int          m_nxt;
    trace_word_t m_word;
    trace_word_t m_q[$];                    // expected entries, oldest first

    nora_core u_dut (.*);

    initial
    begin
        clk6x = 1'b0;
        forever #5 clk6x = ~clk6x;
    end

    task automatic report_failure(input string msg);
        $display("%s at %0t", msg, $time);
        $display("** FAIL **");
        $fatal(1, "stopped on first error");
    endtask

    task automatic check_byte(input cpu_byte_t got, input cpu_byte_t exp, input string what);
        if (got !== exp)
        begin
            $display("Mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
            report_failure("byte compare failed");
        end
    endtask

    task automatic check_word(input trace_word_t got, input trace_word_t exp, input string what);
        if (got !== exp)
        begin
            $display("Mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
            report_failure("trace word compare failed");
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp)
        begin
            $display("Mismatch at %0t: %s got %b expected %b", $time, what, got, exp);
            report_failure("bit compare failed");
        end
    endtask

    // fresh cpu pins and interrupt sources every cycle
    always @(posedge clk6x)
    begin
        {cpu_mx_i, cpu_sync_vpa_i, cpu_mln_i, cpu_vpn_i} <= 4'($random(seed));
        {cpu_vda_i, cpu_ef_i, cpu_rwn_i, cpu_rdy_i}      <= 4'($random(seed));
        cpu_addr_i  <= 16'($random(seed));
        cpu_data_i  <= 8'($random(seed));
        virqn_i     <= 1'($random(seed));
        nmi_req_n_i <= 1'($random(seed));
    end

    // reference model sees the inputs as they stand before each edge
    always @(posedge clk6x)
    begin
        if (!rst_n_i)
        begin
            m_ctrl = '0;
            m_cnt = 0;
            m_run_q = 0;
            m_stop = 1;
            m_latch = 0;
            m_rel = 0;
            m_t02 = 0;
            m_rel_cnt = 0;
            m_q.delete();
        end
        else
        begin
            check_bit(cpu_phi2_o, m_cnt >= HALF, "cpu_phi2_o");
            check_bit(cpu_stopped_o, m_stop, "cpu_stopped_o");
            check_bit(cpu_resn_o, m_ctrl[CTRL_RESN], "cpu_resn_o");
            check_bit(cpu_irqn_o, (virqn_i & ~m_ctrl[2]) | m_ctrl[5], "cpu_irqn_o");
            check_bit(cpu_nmin_o, (nmi_req_n_i & ~m_ctrl[3]) | m_ctrl[6], "cpu_nmin_o");
            check_bit(cpu_abortn_o, ~m_ctrl[4] | m_ctrl[7], "cpu_abortn_o");
            if (m_rel)                      // buffer write takes the earlier m_flag sample
            begin
                m_word = '{bank: m_bank, addr: m_addr, data: cpu_data_i, zero: 3'b000,
                           x_flag: m_xf, resn: m_ctrl[1],
                           irqn: (virqn_i & ~m_ctrl[2]) | m_ctrl[5],
                           nmin: (nmi_req_n_i & ~m_ctrl[3]) | m_ctrl[6],
                           abortn: ~m_ctrl[4] | m_ctrl[7], rdy: cpu_rdy_i, m_flag: m_mflag,
                           sync_vpa: m_sync, mln: m_mln, vpn: m_vpn, vda: m_vda,
                           ef: m_ef, rwn: m_rwn};
                m_q.push_back(m_word);
                if (m_q.size() > DEPTH)
                    void'(m_q.pop_front());
                m_rel_cnt++;
                m_mflag = cpu_mx_i | m_t02 | m_ef;
            end
            if (m_latch)
            begin
                m_bank = m_t02 ? 8'h00 : cpu_data_i;
                m_addr = cpu_addr_i;
                m_xf   = cpu_mx_i | m_t02 | cpu_ef_i;
                m_sync = cpu_sync_vpa_i;
                m_mln  = cpu_mln_i;
                m_vpn  = cpu_vpn_i;
                m_vda  = cpu_vda_i | m_t02;
                m_ef   = cpu_ef_i | m_t02;
                m_rwn  = cpu_rwn_i;
            end
            m_t02 = cputype02_i;
            if (m_cnt == L - 1)
                m_nxt = 0;
            else if (m_cnt == 0 && !m_run_q)
                m_nxt = 0;                  // parked
            else
                m_nxt = m_cnt + 1;
            m_stop  = (m_cnt == 0) && (m_nxt == 0);
            m_latch = (m_nxt == HALF);
            m_rel   = (m_nxt == L - 1);
            m_cnt   = m_nxt;
            m_run_q = m_ctrl[CTRL_RUN];
            if (dbg_wr_i && dbg_addr_i == REG_CTRL)
                m_ctrl = dbg_wdata_i;
            if (dbg_wr_i && dbg_addr_i == REG_TSEL && dbg_wdata_i[3])
                m_q.delete();               // clear beats a same-edge write
        end
    end

    task automatic write_reg(input dbg_addr_t a, input cpu_byte_t d);
        @(posedge clk6x);
        dbg_wr_i    <= 1'b1;
        dbg_addr_i  <= a;
        dbg_wdata_i <= d;
        @(posedge clk6x);
        dbg_wr_i    <= 1'b0;
    endtask

    // rvalid must be low, high, low on the three edges after the strobe
    task automatic read_reg(input dbg_addr_t a, output cpu_byte_t d);
        @(posedge clk6x);
        dbg_rd_i   <= 1'b1;
        dbg_addr_i <= a;
        @(posedge clk6x);
        dbg_rd_i   <= 1'b0;
        if (dbg_rvalid_o !== 1'b0)
            report_failure("dbg_rvalid_o came up in the same cycle as dbg_rd_i");
        @(posedge clk6x);
        if (dbg_rvalid_o !== 1'b1)
            report_failure("dbg_rvalid_o did not pulse one cycle after dbg_rd_i");
        d = dbg_rdata_o;
        @(posedge clk6x);
        if (dbg_rvalid_o !== 1'b0)
            report_failure("dbg_rvalid_o stayed high longer than one cycle");
    endtask

    task automatic wait_stopped();
        int k;
        for (k = 0; k < 2 * L + 4; k++)
        begin
            @(posedge clk6x);
            if (cpu_stopped_o === 1'b1)
                break;
        end
        if (cpu_stopped_o !== 1'b1)
            report_failure("CPU never stopped after run was cleared");
        check_bit(cpu_phi2_o, 1'b0, "phi2 while stopped");
    endtask

    // let the cpu run about n cycles, then park it
    task automatic run_cycles(input int n, input logic t02);
        int start;
        @(posedge clk6x);
        cputype02_i <= t02;
        write_reg(REG_CTRL, 8'h03);         // run, out of reset
        start = m_rel_cnt;
        while (m_rel_cnt - start < n - 1)
            @(posedge clk6x);
        write_reg(REG_CTRL, 8'h02);
        wait_stopped();
    endtask

    // every valid entry by age against the model queue
    task automatic check_entries();
        int          n;
        int          b;
        cpu_byte_t   d;
        logic [47:0] got;
        n = m_q.size();
        write_reg(REG_TSEL, 8'h00);
        read_reg(REG_TSEL, d);
        check_byte(d, {4'(n), 4'h0}, "REG_TSEL count");
        for (int sel = 0; sel < n; sel++)
        begin
            write_reg(REG_TSEL, 8'(sel));
            read_reg(REG_TSEL, d);
            check_byte(d, {4'(n), 1'b0, 3'(sel)}, "REG_TSEL select");
            for (b = 0; b < 6; b++)
            begin
                read_reg(dbg_addr_t'(REG_TBYTE0 + b), d);
                got[b*8 +: 8] = d;
            end
            check_word(trace_word_t'(got), m_q[n - 1 - sel], "trace entry");
        end
    endtask

    initial
    begin
        #(LIMIT * 10);
        $display("watchdog ran out after %0d clock periods, test is stuck", LIMIT);
        $display("** FAIL **");
        $fatal(1, "timeout");
    end

    initial
    begin
        cpu_byte_t d;
        cpu_byte_t rb;
        int        k;
        rst_n_i     = 1'b0;
        cputype02_i = 1'b0;
        dbg_wr_i    = 1'b0;
        dbg_rd_i    = 1'b0;
        dbg_addr_i  = '0;
        dbg_wdata_i = '0;
        {cpu_addr_i, cpu_data_i, cpu_mx_i, cpu_sync_vpa_i, cpu_mln_i} = '0;
        {cpu_vpn_i, cpu_vda_i, cpu_ef_i, cpu_rwn_i, cpu_rdy_i} = '0;
        virqn_i     = 1'b1;
        nmi_req_n_i = 1'b1;
        repeat (16) @(posedge clk6x);
        rst_n_i <= 1'b1;

        // after reset
        @(posedge clk6x);
        check_bit(cpu_phi2_o, 1'b0, "phi2 after reset");
        check_bit(cpu_stopped_o, 1'b1, "stopped after reset");
        check_bit(cpu_resn_o, 1'b0, "resn after reset");
        read_reg(REG_TSEL, d);
        check_byte(d, 8'h00, "REG_TSEL after reset");
        read_reg(REG_CTRL, d);
        check_byte(d, 8'h00, "REG_CTRL after reset");

        // first phi2 rise here and the model checks the rest cycle by cycle
        write_reg(REG_CTRL, 8'h03);
        k = 0;
        do
        begin
            @(posedge clk6x);
            k++;
        end
        while (cpu_phi2_o !== 1'b1 && k < 4 * L);
        check_byte(8'(k), 8'(HALF + 2), "edges to first phi2 sample");
        repeat (3 * L) @(posedge clk6x);
        write_reg(REG_CTRL, 8'h02);
        wait_stopped();
        write_reg(REG_TSEL, 8'h08);         // drop warm-up entries

        // short runs on a 65C02 or a 65C816
        for (int r = 0; r < 5; r++)
        begin
            write_reg(REG_TSEL, 8'h08);
            run_cycles(3 + int'($unsigned($random(seed)) % 5), 1'($random(seed)));
            check_entries();
        end

        // wrap and clear
        write_reg(REG_TSEL, 8'h08);
        run_cycles(20, 1'b0);
        read_reg(REG_TSEL, d);
        check_byte(d, {4'(DEPTH), 4'h0}, "REG_TSEL count after wrap");
        check_entries();
        write_reg(REG_TSEL, 8'h08);
        read_reg(REG_TSEL, d);
        check_byte(d, 8'h00, "REG_TSEL after clear");

        // gating with random control bytes while the cpu stays parked
        for (int i = 0; i < 40; i++)
        begin
            d = 8'($random(seed));
            d[CTRL_RUN] = 1'b0;
            write_reg(REG_CTRL, d);
            repeat (2) @(posedge clk6x);
            read_reg(REG_CTRL, rb);
            check_byte(rb, d, "REG_CTRL readback");
        end

        // unmapped addresses
        for (int a = 8; a < 16; a++)
        begin
            read_reg(dbg_addr_t'(a), d);
            check_byte(d, 8'hFF, "unmapped read");
        end

        $display("** PASS **");
        $finish;
    end

endmodule

`default_nettype wire

/* src/bus_sampler.sv */
// bus_sampler: cpu pin sampling at the phase strobes, trace word assembly
`timescale 1ns/1ps
`default_nettype none

module bus_sampler (
    input  wire                  clk6x,
    input  wire                  rst_n_i,
    input  wire                  latch_ad_i,
    input  wire                  release_wr_i,
    input  wire nora_pkg::cpu_addr_t cpu_addr_i,
    input  wire nora_pkg::cpu_byte_t cpu_data_i,
    input  wire                  cputype02_i,       // 1 = 65C02, 0 = 65C816
    input  wire                  cpu_mx_i,
    input  wire                  cpu_sync_vpa_i,
    input  wire                  cpu_mln_i,
    input  wire                  cpu_vpn_i,
    input  wire                  cpu_vda_i,
    input  wire                  cpu_ef_i,
    input  wire                  cpu_rwn_i,
    input  wire                  cpu_rdy_i,
    input  wire                  cpu_resn_i,        // live control lines from icd_regs
    input  wire                  cpu_irqn_i,
    input  wire                  cpu_nmin_i,
    input  wire                  cpu_abortn_i,
    output nora_pkg::trace_word_t trace_word_o
);

    import nora_pkg::*;

    logic      type02_q;        // board strap, resampled every cycle
    cpu_addr_t addr_q;
    cpu_byte_t bank_q;
    logic      x_flag_q;
    logic      m_flag_q;
    logic      sync_vpa_q;
    logic      mln_q;
    logic      vpn_q;
    logic      vda_q;
    logic      ef_q;
    logic      rwn_q;

    always_ff @(posedge clk6x)
    begin
        if (!rst_n_i)
            type02_q <= 1'b0;
        else
            type02_q <= cputype02_i;
    end

    always_ff @(posedge clk6x)
    begin
        if (latch_ad_i)                                     // phi2 rising
        begin
            addr_q     <= cpu_addr_i;
            bank_q     <= type02_q ? 8'h00 : cpu_data_i;    // 816 drives bank while phi2 low
            x_flag_q   <= cpu_mx_i | type02_q | cpu_ef_i;   // 8-bit index in emulation
            sync_vpa_q <= cpu_sync_vpa_i;
            mln_q      <= cpu_mln_i;
            vpn_q      <= cpu_vpn_i;
            vda_q      <= cpu_vda_i | type02_q;             // 65C02 has no vda, always valid
            ef_q       <= cpu_ef_i | type02_q;
            rwn_q      <= cpu_rwn_i;
        end
        if (release_wr_i)
            m_flag_q   <= cpu_mx_i | type02_q | ef_q;       // M is valid at phi2 falling
    end

    always_comb
    begin
        trace_word_o.bank     = bank_q;
        trace_word_o.addr     = addr_q;
        trace_word_o.data     = cpu_data_i;     // live, taken by the buffer at release_wr
        trace_word_o.zero     = 3'b000;
        trace_word_o.x_flag   = x_flag_q;
        trace_word_o.resn     = cpu_resn_i;
        trace_word_o.irqn     = cpu_irqn_i;
        trace_word_o.nmin     = cpu_nmin_i;
        trace_word_o.abortn   = cpu_abortn_i;
        trace_word_o.rdy      = cpu_rdy_i;      // live
        trace_word_o.m_flag   = m_flag_q;
        trace_word_o.sync_vpa = sync_vpa_q;
        trace_word_o.mln      = mln_q;
        trace_word_o.vpn      = vpn_q;
        trace_word_o.vda      = vda_q;
        trace_word_o.ef       = ef_q;
        trace_word_o.rwn      = rwn_q;
    end

endmodule

`default_nettype wire

/* src/cpu_phaser.sv */
// cpu_phaser: cpu clock phase counter, phi2, latch and write-release strobes, stopped level
`timescale 1ns/1ps
`default_nettype none

module cpu_phaser #(
    parameter int CYCLE_LEN = 6             // clk6x cycles per cpu cycle, even, >= 4
) (
    input  wire  clk6x,
    input  wire  rst_n_i,
    input  wire  run_cpu_i,
    output logic cphi2_o,                   // cpu clock
    output logic latch_ad_o,                // first cycle of phi2 high
    output logic release_wr_o,              // last cycle of the cpu cycle
    output logic stopped_o                  // parked at counter 0
);

    localparam int CW   = $clog2(CYCLE_LEN);
    localparam int HALF = CYCLE_LEN / 2;

    logic [CW-1:0] cnt_q;
    logic [CW-1:0] cnt_nxt;
    logic          run_q;                   // run seen one cycle late at the park point

    // advance, wrap at the end, park at 0 while run is low
    always_comb
    begin
        if (cnt_q == CW'(CYCLE_LEN - 1))
            cnt_nxt = '0;
        else if ((cnt_q == '0) && !run_q)
            cnt_nxt = '0;                   // hold, current cpu cycle already done
        else
            cnt_nxt = cnt_q + 1'b1;
    end

    // outputs registered from the next count, so they line up with cnt_q
    always_ff @(posedge clk6x)
    begin
        if (!rst_n_i)
        begin
            cnt_q        <= '0;
            run_q        <= 1'b0;
            cphi2_o      <= 1'b0;
            latch_ad_o   <= 1'b0;
            release_wr_o <= 1'b0;
            stopped_o    <= 1'b1;           // parked out of reset
        end
        else
        begin
            run_q        <= run_cpu_i;
            cnt_q        <= cnt_nxt;
            cphi2_o      <= (cnt_nxt >= CW'(HALF));             // second half high
            latch_ad_o   <= (cnt_nxt == CW'(HALF));
            release_wr_o <= (cnt_nxt == CW'(CYCLE_LEN - 1));
            stopped_o    <= (cnt_q == '0) && (cnt_nxt == '0);   // held at 0
        end
    end

    // the two strobes sit in different phases of the cycle
    a_strobes_apart: assert property (@(posedge clk6x) disable iff (!rst_n_i)
        !(latch_ad_o && release_wr_o));

    // no clock edge reaches the cpu while parked
    a_phi2_quiet: assert property (@(posedge clk6x) disable iff (!rst_n_i)
        stopped_o |=> $stable(cphi2_o));

endmodule

`default_nettype wire

/* src/icd_regs.sv */
// icd_regs: debug register port, control register, interrupt line gating, trace readback
`timescale 1ns/1ps
`default_nettype none

module icd_regs #(
    parameter int TRACE_DEPTH_BITS = 3
) (
    input  wire                         clk6x,
    input  wire                         rst_n_i,
    input  wire                         dbg_wr_i,
    input  wire                         dbg_rd_i,
    input  wire nora_pkg::dbg_addr_t    dbg_addr_i,
    input  wire nora_pkg::cpu_byte_t    dbg_wdata_i,
    output nora_pkg::cpu_byte_t         dbg_rdata_o,
    output logic                        dbg_rvalid_o,
    input  wire                         virqn_i,
    input  wire                         nmi_req_n_i,
    output logic                        run_cpu_o,
    output logic                        cpu_resn_o,
    output logic                        cpu_irqn_o,
    output logic                        cpu_nmin_o,
    output logic                        cpu_abortn_o,
    output logic [TRACE_DEPTH_BITS-1:0] trace_sel_o,
    output logic                        trace_clear_o,
    input  wire nora_pkg::trace_word_t  trace_word_i,
    input  wire [TRACE_DEPTH_BITS:0]    trace_count_i
);

    import nora_pkg::*;

    cpu_byte_t                     ctrl_q;
    cpu_byte_t                     rd_mux;
    logic [$bits(trace_word_t)-1:0] tw_bits;
    logic [2:0]                    tbyte_sel;
    logic                          wr_ctrl;
    logic                          wr_tsel;

    assign wr_ctrl       = dbg_wr_i && (dbg_addr_i == REG_CTRL);
    assign wr_tsel       = dbg_wr_i && (dbg_addr_i == REG_TSEL);
    assign trace_clear_o = wr_tsel && dbg_wdata_i[3];   // buffer clears on the write edge

    always_ff @(posedge clk6x)
    begin
        if (!rst_n_i)
        begin
            ctrl_q       <= '0;         // stopped, cpu held in reset
            trace_sel_o  <= '0;
            dbg_rvalid_o <= 1'b0;
        end
        else
        begin
            if (wr_ctrl)
                ctrl_q <= dbg_wdata_i;
            if (wr_tsel)
                trace_sel_o <= dbg_wdata_i[TRACE_DEPTH_BITS-1:0];
            dbg_rvalid_o <= dbg_rd_i;
        end
    end

    // cpu control lines, block overrides force
    assign run_cpu_o    = ctrl_q[CTRL_RUN];
    assign cpu_resn_o   = ctrl_q[CTRL_RESN];
    assign cpu_irqn_o   = (virqn_i & ~ctrl_q[CTRL_FORCE_IRQ]) | ctrl_q[CTRL_BLOCK_IRQ];
    assign cpu_nmin_o   = (nmi_req_n_i & ~ctrl_q[CTRL_FORCE_NMI]) | ctrl_q[CTRL_BLOCK_NMI];
    assign cpu_abortn_o = ~ctrl_q[CTRL_FORCE_ABORT] | ctrl_q[CTRL_BLOCK_ABORT];

    assign tw_bits   = trace_word_i;
    assign tbyte_sel = 3'(dbg_addr_i - REG_TBYTE0);     // 0..5 for the byte registers

    always_comb
    begin
        case (dbg_addr_i)
            REG_CTRL:
                rd_mux = ctrl_q;
            REG_TSEL:
                rd_mux = {4'(trace_count_i), 1'b0, 3'(trace_sel_o)};
            REG_TBYTE0, REG_TBYTE1, REG_TBYTE2, REG_TBYTE3, REG_TBYTE4, REG_TBYTE5:
                rd_mux = tw_bits[tbyte_sel * 8 +: 8];   // only meaningful while stopped
            default:
                rd_mux = 8'hFF;                         // unmapped
        endcase
    end

    always_ff @(posedge clk6x)
    begin
        if (dbg_rd_i)
            dbg_rdata_o <= rd_mux;
    end

    a_rvalid_after_rd: assert property (@(posedge clk6x) disable iff (!rst_n_i)
        dbg_rvalid_o |-> $past(dbg_rd_i));

endmodule

`default_nettype wire

/* src/nora_core.sv */
// nora_core: top level joining phaser, bus sampler, trace buffer and debug registers
`timescale 1ns/1ps
`default_nettype none

module nora_core #(
    parameter int CYCLE_LEN        = 6,
    parameter int TRACE_DEPTH_BITS = 3
) (
    input  wire                      clk6x,
    input  wire                      rst_n_i,
    // cpu pins
    input  wire nora_pkg::cpu_addr_t cpu_addr_i,
    input  wire nora_pkg::cpu_byte_t cpu_data_i,
    input  wire                      cpu_mx_i,
    input  wire                      cpu_sync_vpa_i,
    input  wire                      cpu_mln_i,
    input  wire                      cpu_vpn_i,
    input  wire                      cpu_vda_i,
    input  wire                      cpu_ef_i,
    input  wire                      cpu_rwn_i,
    input  wire                      cpu_rdy_i,
    // board strap and interrupt sources
    input  wire                      cputype02_i,
    input  wire                      virqn_i,
    input  wire                      nmi_req_n_i,
    // debug port
    input  wire                      dbg_wr_i,
    input  wire                      dbg_rd_i,
    input  wire nora_pkg::dbg_addr_t dbg_addr_i,
    input  wire nora_pkg::cpu_byte_t dbg_wdata_i,
    // cpu control
    output wire                      cpu_phi2_o,
    output wire                      cpu_resn_o,
    output wire                      cpu_irqn_o,
    output wire                      cpu_nmin_o,
    output wire                      cpu_abortn_o,
    // status and debug readback
    output wire                      cpu_stopped_o,
    output nora_pkg::cpu_byte_t      dbg_rdata_o,
    output wire                      dbg_rvalid_o
);

    wire                        run_cpu;
    wire                        latch_ad;       // phi2 rising
    wire                        release_wr;     // end of cpu cycle, trace capture
    nora_pkg::trace_word_t      trace_word;     // live word from the sampler
    nora_pkg::trace_word_t      trace_rd;       // selected stored entry
    wire [TRACE_DEPTH_BITS-1:0] trace_sel;
    wire                        trace_clear;
    wire [TRACE_DEPTH_BITS:0]   trace_count;

    cpu_phaser #(.CYCLE_LEN(CYCLE_LEN)) u_phaser (
        .clk6x        (clk6x),
        .rst_n_i      (rst_n_i),
        .run_cpu_i    (run_cpu),
        .cphi2_o      (cpu_phi2_o),
        .latch_ad_o   (latch_ad),
        .release_wr_o (release_wr),
        .stopped_o    (cpu_stopped_o)
    );

    bus_sampler u_sampler (
        .clk6x          (clk6x),
        .rst_n_i        (rst_n_i),
        .latch_ad_i     (latch_ad),
        .release_wr_i   (release_wr),
        .cpu_addr_i     (cpu_addr_i),
        .cpu_data_i     (cpu_data_i),
        .cputype02_i    (cputype02_i),
        .cpu_mx_i       (cpu_mx_i),
        .cpu_sync_vpa_i (cpu_sync_vpa_i),
        .cpu_mln_i      (cpu_mln_i),
        .cpu_vpn_i      (cpu_vpn_i),
        .cpu_vda_i      (cpu_vda_i),
        .cpu_ef_i       (cpu_ef_i),
        .cpu_rwn_i      (cpu_rwn_i),
        .cpu_rdy_i      (cpu_rdy_i),
        .cpu_resn_i     (cpu_resn_o),   // control lines as driven to the cpu
        .cpu_irqn_i     (cpu_irqn_o),
        .cpu_nmin_i     (cpu_nmin_o),
        .cpu_abortn_i   (cpu_abortn_o),
        .trace_word_o   (trace_word)
    );

    trace_buffer #(.TRACE_DEPTH_BITS(TRACE_DEPTH_BITS)) u_trace (
        .clk6x   (clk6x),
        .rst_n_i (rst_n_i),
        .wr_i    (release_wr),
        .word_i  (trace_word),
        .clear_i (trace_clear),
        .sel_i   (trace_sel),
        .word_o  (trace_rd),
        .count_o (trace_count)
    );

    icd_regs #(.TRACE_DEPTH_BITS(TRACE_DEPTH_BITS)) u_icd (
        .clk6x         (clk6x),
        .rst_n_i       (rst_n_i),
        .dbg_wr_i      (dbg_wr_i),
        .dbg_rd_i      (dbg_rd_i),
        .dbg_addr_i    (dbg_addr_i),
        .dbg_wdata_i   (dbg_wdata_i),
        .dbg_rdata_o   (dbg_rdata_o),
        .dbg_rvalid_o  (dbg_rvalid_o),
        .virqn_i       (virqn_i),
        .nmi_req_n_i   (nmi_req_n_i),
        .run_cpu_o     (run_cpu),
        .cpu_resn_o    (cpu_resn_o),
        .cpu_irqn_o    (cpu_irqn_o),
        .cpu_nmin_o    (cpu_nmin_o),
        .cpu_abortn_o  (cpu_abortn_o),
        .trace_sel_o   (trace_sel),
        .trace_clear_o (trace_clear),
        .trace_word_i  (trace_rd),
        .trace_count_i (trace_count)
    );

endmodule

`default_nettype wire

/* src/nora_pkg.sv */
// nora package: cpu bus types, trace word layout, debug register map, control bit positions
`default_nettype none

package nora_pkg;

    typedef logic [15:0] cpu_addr_t;    // cpu address bus
    typedef logic [7:0]  cpu_byte_t;    // data byte or 65C816 bank byte
    typedef logic [3:0]  dbg_addr_t;    // debug register address

    // one cpu cycle, 48 bits, byte 5 (bank) down to byte 0 (status)
    typedef struct packed {
        cpu_byte_t  bank;       // byte 5, zero on a 65C02
        cpu_addr_t  addr;       // bytes 4 and 3
        cpu_byte_t  data;       // byte 2, data bus at release_wr
        logic [2:0] zero;       // byte 1 from here
        logic       x_flag;     // X on 65C816, forced 1 in emulation or on 65C02
        logic       resn;
        logic       irqn;
        logic       nmin;
        logic       abortn;
        logic       rdy;        // byte 0 from here
        logic       m_flag;     // M, sampled late in the cycle
        logic       sync_vpa;   // SYNC (65C02) or VPA (65C816)
        logic       mln;
        logic       vpn;
        logic       vda;
        logic       ef;
        logic       rwn;
    } trace_word_t;

    // debug register map
    localparam dbg_addr_t REG_CTRL   = 4'd0;
    localparam dbg_addr_t REG_TSEL   = 4'd1;    // wr: sel 2:0, clear 3; rd: sel 2:0, count 7:4
    localparam dbg_addr_t REG_TBYTE0 = 4'd2;    // selected entry, byte 0
    localparam dbg_addr_t REG_TBYTE1 = 4'd3;
    localparam dbg_addr_t REG_TBYTE2 = 4'd4;
    localparam dbg_addr_t REG_TBYTE3 = 4'd5;
    localparam dbg_addr_t REG_TBYTE4 = 4'd6;
    localparam dbg_addr_t REG_TBYTE5 = 4'd7;    // bank byte

    // bit positions in REG_CTRL
    localparam int CTRL_RUN         = 0;    // let the phaser run
    localparam int CTRL_RESN        = 1;    // 0 holds the cpu in reset
    localparam int CTRL_FORCE_IRQ   = 2;
    localparam int CTRL_FORCE_NMI   = 3;
    localparam int CTRL_FORCE_ABORT = 4;
    localparam int CTRL_BLOCK_IRQ   = 5;    // block wins over force
    localparam int CTRL_BLOCK_NMI   = 6;
    localparam int CTRL_BLOCK_ABORT = 7;

endpackage

`default_nettype wire

/* src/trace_buffer.sv */
// trace_buffer: circular store of the newest trace words, entry count, read by age
`timescale 1ns/1ps
`default_nettype none

module trace_buffer #(
    parameter int TRACE_DEPTH_BITS = 3
) (
    input  wire                         clk6x,
    input  wire                         rst_n_i,
    input  wire                         wr_i,
    input  wire nora_pkg::trace_word_t  word_i,
    input  wire                         clear_i,
    input  wire [TRACE_DEPTH_BITS-1:0]  sel_i,      // 0 = newest
    output nora_pkg::trace_word_t       word_o,
    output logic [TRACE_DEPTH_BITS:0]   count_o
);

    import nora_pkg::*;

    localparam int DEPTH = 1 << TRACE_DEPTH_BITS;
    localparam logic [TRACE_DEPTH_BITS:0] FULL = (TRACE_DEPTH_BITS + 1)'(DEPTH);

    trace_word_t                 mem [DEPTH];
    logic [TRACE_DEPTH_BITS-1:0] wr_ptr_q;          // next slot to write
    logic [TRACE_DEPTH_BITS-1:0] rd_idx;
    logic                        rd_hit;

    assign rd_idx = wr_ptr_q + ~sel_i;              // wr_ptr - 1 - sel, wraps
    assign rd_hit = {1'b0, sel_i} < count_o;        // older than the count reads zero

    always_ff @(posedge clk6x)
    begin
        if (!rst_n_i || clear_i)
        begin
            wr_ptr_q <= '0;
            count_o  <= '0;
        end
        else if (wr_i)
        begin
            wr_ptr_q <= wr_ptr_q + 1'b1;
            if (count_o != FULL)
                count_o <= count_o + 1'b1;          // saturate at depth
        end
    end

    always_ff @(posedge clk6x)
    begin
        if (wr_i)
            mem[wr_ptr_q] <= word_i;
        word_o <= rd_hit ? mem[rd_idx] : '0;
    end

    a_count_max: assert property (@(posedge clk6x) disable iff (!rst_n_i)
        count_o <= FULL);

endmodule

`default_nettype wire
